// File: compile.f
+incdir+include
hdl/trellisPkg.sv
hdl/samplePairer.sv
hdl/branchMetricUnit.sv
hdl/acsUnit.sv
hdl/survivorRegister.sv
hdl/decisionQueue.sv
hdl/trellisDetector.sv
testbench/tbTrellisDetector.sv

// File: hdl/acsUnit.sv
/* Four-state add-compare-select with metric normalization; reports the
   survivor choice per state and the current best state */

`timescale 1ns/1ns
`include "trellis_cfg.svh"

module acsUnit import trellisPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         advance,
  input  branchSet_t   branches,
  input  logic         branchValid,
  output acsDecision_t select,
  output logic         selectValid
);

  // one guard bit for the add
  localparam int extW = `METRIC_W + 1;
  // half of the positive range triggers the rescale
  localparam logic signed [extW-1:0] halfPos      = extW'(1) << (`METRIC_W - 2);
  localparam logic signed [extW-1:0] quarterRange = extW'(1) << (`METRIC_W - 2);

  logic signed [`METRIC_W-1:0] stateMetric [4];
  logic signed [extW-1:0]      candLow [4];
  logic signed [extW-1:0]      candHigh [4];
  logic signed [extW-1:0]      newMetric [4];
  logic signed [extW-1:0]      normMetric [4];
  logic signed [extW-1:0]      bestMetric;
  logic [3:0]                  survBit;
  pathState_e                  bestState;

  // ------------------------------------------------------------------------
  // add and compare
  // ------------------------------------------------------------------------
  // new state {a, b} is reached from old {0, a} or {1, a} with new bit b
  always_comb begin
    int predLow;
    int predHigh;
    for (int ns = 0; ns < 4; ns++) begin
      predLow      = ns / 2;
      predHigh     = 2 + ns / 2;
      candLow[ns]  = stateMetric[predLow] +
                     $signed(branches.metric[2 * predLow + ns % 2]);
      candHigh[ns] = stateMetric[predHigh] +
                     $signed(branches.metric[2 * predHigh + ns % 2]);
      // ties go to the low predecessor
      survBit[ns]   = candHigh[ns] > candLow[ns];
      newMetric[ns] = survBit[ns] ? candHigh[ns] : candLow[ns];
    end
  end

  // best state, lowest index on ties
  always_comb begin
    bestState  = S00;
    bestMetric = newMetric[S00];
    for (int ns = 1; ns < 4; ns++) begin
      if (newMetric[ns] > bestMetric) begin
        bestMetric = newMetric[ns];
        bestState  = pathState_e'(ns);
      end
    end
  end

  // rescale all four together so differences stay intact
  always_comb begin
    for (int ns = 0; ns < 4; ns++) begin
      if (bestMetric >= halfPos) begin
        normMetric[ns] = newMetric[ns] - quarterRange;
      end else begin
        normMetric[ns] = newMetric[ns];
      end
    end
  end

  // ------------------------------------------------------------------------
  // metric state, trellis starts in S00
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      stateMetric[S00] <= '0;
      stateMetric[S01] <= -quarterRange[`METRIC_W-1:0];
      stateMetric[S10] <= -quarterRange[`METRIC_W-1:0];
      stateMetric[S11] <= -quarterRange[`METRIC_W-1:0];
      selectValid      <= 1'b0;
    end else if (advance) begin
      selectValid <= branchValid;
      if (branchValid) begin
        for (int ns = 0; ns < 4; ns++) begin
          stateMetric[ns] <= normMetric[ns][`METRIC_W-1:0];
        end
      end
    end
  end

  // decision output
  always_ff @(posedge clk) begin
    if (advance && branchValid) begin
      select.survivor <= survBit;
      select.best     <= bestState;
    end
  end

endmodule

// File: hdl/branchMetricUnit.sv
/* Branch metrics: two-stage correlation of one symbol against the eight
   trellis-transition templates */

`timescale 1ns/1ns
`include "trellis_cfg.svh"

module branchMetricUnit import trellisPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        advance,
  input  symbolPair_t pairIn,
  input  logic        pairValid,
  output branchSet_t  branches,
  output logic        branchValid
);

  // sample times 4-bit coefficient
  localparam int prodW = `SAMPLE_W + 4;

  logic signed [`SAMPLE_W-1:0] comp [4];
  logic signed [prodW-1:0]     prodReg [8][4];
  logic signed [`METRIC_W-1:0] sums [8];
  logic                        prodValid;

  // component order matches the template columns
  assign comp[0] = pairIn.s0.i;
  assign comp[1] = pairIn.s0.q;
  assign comp[2] = pairIn.s1.i;
  assign comp[3] = pairIn.s1.q;

  // ------------------------------------------------------------------------
  // stage 1: all 32 products
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (advance && pairValid) begin
      for (int t = 0; t < 8; t++) begin
        for (int c = 0; c < 4; c++) begin
          prodReg[t][c] <= comp[c] * symbolTemplate[t][c];
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // stage 2: sum per transition, bigger = closer match
  // ------------------------------------------------------------------------
  always_comb begin
    logic signed [`METRIC_W-1:0] acc;
    for (int t = 0; t < 8; t++) begin
      acc = '0;
      for (int c = 0; c < 4; c++) begin
        // sign extended into metric width
        acc = acc + prodReg[t][c];
      end
      sums[t] = acc;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && prodValid) begin
      for (int t = 0; t < 8; t++) begin
        branches.metric[t] <= sums[t];
      end
    end
  end

  // valid pipe, frozen together with the data
  always_ff @(posedge clk) begin
    if (reset) begin
      prodValid   <= 1'b0;
      branchValid <= 1'b0;
    end else if (advance) begin
      prodValid   <= pairValid;
      branchValid <= prodValid;
    end
  end

endmodule

// File: hdl/decisionQueue.sv
/* Output FIFO for decided bits, valid/ready toward the sink and a space
   flag that throttles the whole pipeline */

`timescale 1ns/1ns
`include "trellis_cfg.svh"

module decisionQueue (
  input  logic clk,
  input  logic reset,
  input  logic decidedBit,
  input  logic decidedValid,
  output logic spaceAvail,
  output logic bitOut,
  output logic bitValid,
  input  logic bitReady
);

  localparam int ptrW = $clog2(`QUEUE_DEPTH);
  localparam int cntW = $clog2(`QUEUE_DEPTH + 1);
  // free entries needed to cover the bits still in flight
  localparam int minFree = 3;

  logic            mem [`QUEUE_DEPTH];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic [cntW-1:0] countNext;
  logic            wrEn;
  logic            rdEn;

  assign wrEn     = decidedValid;
  assign rdEn     = bitValid && bitReady;
  assign bitValid = count != '0;
  assign bitOut   = mem[rdPtr];

  always_comb begin
    case ({wrEn, rdEn})
      2'b10:   countNext = count + 1'b1;
      2'b01:   countNext = count - 1'b1;
      default: countNext = count;
    endcase
  end

  // pointers, count and space flag
  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      count      <= '0;
      spaceAvail <= 1'b0;
    end else begin
      if (wrEn) begin
        wrPtr <= (wrPtr == ptrW'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (rdEn) begin
        rdPtr <= (rdPtr == ptrW'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      count      <= countNext;
      spaceAvail <= (cntW'(`QUEUE_DEPTH) - countNext) >= cntW'(minFree);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrPtr] <= decidedBit;
    end
  end

endmodule

// File: hdl/samplePairer.sv
/* Input side: accepts single I/Q samples under valid/ready and forms
   two-sample symbols for the branch metric stage */

`timescale 1ns/1ns

module samplePairer import trellisPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        advance,
  input  iqSample_t   sampleIn,
  input  logic        sampleValid,
  output logic        sampleReady,
  output symbolPair_t pairOut,
  output logic        pairValid
);

  // low = waiting for first sample of a symbol
  logic      phase;
  logic      accept;
  iqSample_t firstSample;

  // no intake while the pipeline is frozen
  assign sampleReady = advance;
  assign accept      = sampleValid && advance;

  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      phase     <= 1'b0;
      pairValid <= 1'b0;
    end else if (advance) begin
      // one-cycle pulse per completed symbol
      pairValid <= accept && phase;
      if (accept) begin
        phase <= ~phase;
      end
    end
  end

  // sample holding and pair output
  always_ff @(posedge clk) begin
    if (accept) begin
      if (!phase) begin
        firstSample <= sampleIn;
      end else begin
        pairOut.s0 <= firstSample;
        pairOut.s1 <= sampleIn;
      end
    end
  end

endmodule

// File: hdl/survivorRegister.sv
/* Register-exchange survivor memory; emits the oldest bit on the best
   path once the paths have filled */

`timescale 1ns/1ns
`include "trellis_cfg.svh"

module survivorRegister import trellisPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         advance,
  input  acsDecision_t select,
  input  logic         selectValid,
  output logic         decidedBit,
  output logic         decidedValid
);

  localparam int fillW = $clog2(`TRACE_DEPTH + 1);

  // newest bit in the lsb
  logic [`TRACE_DEPTH-1:0] path [4];
  logic [fillW-1:0]        fillCount;
  logic                    filled;
  logic [1:0]              bestPred;
  logic                    absorb;

  assign absorb = advance && selectValid;
  assign filled = fillCount == fillW'(`TRACE_DEPTH);

  // predecessor of the best new state
  assign bestPred = {select.survivor[select.best], select.best[1]};

  // ------------------------------------------------------------------------
  // path exchange
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (absorb) begin
      for (int ns = 0; ns < 4; ns++) begin
        // winner's history plus this state's own newest bit
        if (select.survivor[ns]) begin
          path[ns] <= {path[2 + ns / 2][`TRACE_DEPTH-2:0], 1'(ns % 2)};
        end else begin
          path[ns] <= {path[ns / 2][`TRACE_DEPTH-2:0], 1'(ns % 2)};
        end
      end
      // bit shifted out of the best path, TRACE_DEPTH symbols old
      decidedBit <= path[bestPred][`TRACE_DEPTH-1];
    end
  end

  // ------------------------------------------------------------------------
  // fill tracking and valid
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      fillCount    <= '0;
      decidedValid <= 1'b0;
    end else if (advance) begin
      decidedValid <= selectValid && filled;
      // saturate once full
      if (selectValid && !filled) begin
        fillCount <= fillCount + 1'b1;
      end
    end else begin
      // queue took the bit on the last edge, single pulse only
      decidedValid <= 1'b0;
    end
  end

endmodule

// File: hdl/trellisDetector.sv
/* SOQPSK trellis detector top: sample pairing, branch metrics, ACS,
   survivor memory and output queue under one advance enable */

`timescale 1ns/1ns

module trellisDetector import trellisPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  iqSample_t sampleIn,
  input  logic      sampleValid,
  output logic      sampleReady,
  output logic      bitOut,
  output logic      bitValid,
  input  logic      bitReady
);

  logic         advance;
  logic         spaceAvail;
  symbolPair_t  pairOut;
  logic         pairValid;
  branchSet_t   branches;
  logic         branchValid;
  acsDecision_t select;
  logic         selectValid;
  logic         decidedBit;
  logic         decidedValid;

  // whole pipeline steps only while the queue has room
  assign advance = spaceAvail;

  samplePairer pairer_i (
    .clk, .reset, .advance, .sampleIn, .sampleValid, .sampleReady,
    .pairOut, .pairValid
  );

  branchMetricUnit bmu_i (
    .clk, .reset, .advance, .pairIn(pairOut), .pairValid, .branches, .branchValid
  );

  acsUnit acs_i (
    .clk, .reset, .advance, .branches, .branchValid, .select, .selectValid
  );

  survivorRegister surv_i (
    .clk, .reset, .advance, .select, .selectValid, .decidedBit, .decidedValid
  );

  decisionQueue queue_i (
    .clk, .reset, .decidedBit, .decidedValid, .spaceAvail, .bitOut, .bitValid,
    .bitReady
  );

endmodule

// File: hdl/trellisPkg.sv
/* Shared types for the SOQPSK trellis detector: samples, symbol pairs,
   branch and ACS results, trellis states and the symbol template table */

`include "trellis_cfg.svh"

package trellisPkg;

  // ------------------------------------------------------------------------
  // sample path types
  // ------------------------------------------------------------------------

  // one complex sample
  typedef struct packed {
    logic signed [`SAMPLE_W-1:0] i;
    logic signed [`SAMPLE_W-1:0] q;
  } iqSample_t;

  // two samples per symbol, earlier one in s0
  typedef struct packed {
    iqSample_t s0;
    iqSample_t s1;
  } symbolPair_t;

  // one correlation per transition, index is {oldState, newBit}
  typedef struct packed {
    logic [7:0][`METRIC_W-1:0] metric;
  } branchSet_t;

  // ------------------------------------------------------------------------
  // trellis types
  // ------------------------------------------------------------------------

  // state named by the last two bits, older bit in the msb
  typedef enum logic [1:0] {
    S00,
    S01,
    S10,
    S11
  } pathState_e;

  // survivor select per new state (1 = predecessor with older bit 1)
  typedef struct packed {
    logic [3:0] survivor;
    pathState_e best;
  } acsDecision_t;

  // expected I0, Q0, I1, Q1 per history {b(n-2), b(n-1), b(n)}
  // I0 = 2d(n), Q0 = d(n-1), I1 = 2d(n)d(n-1), Q1 = d(n)d(n-2)
  // with d = +1 for a one bit; every entry has the same energy
  localparam logic signed [3:0] symbolTemplate [8][4] = '{
    '{-4'sd2, -4'sd1,  4'sd2,  4'sd1},
    '{ 4'sd2, -4'sd1, -4'sd2, -4'sd1},
    '{-4'sd2,  4'sd1, -4'sd2,  4'sd1},
    '{ 4'sd2,  4'sd1,  4'sd2, -4'sd1},
    '{-4'sd2, -4'sd1,  4'sd2, -4'sd1},
    '{ 4'sd2, -4'sd1, -4'sd2,  4'sd1},
    '{-4'sd2,  4'sd1, -4'sd2, -4'sd1},
    '{ 4'sd2,  4'sd1,  4'sd2,  4'sd1}
  };

endpackage

// File: include/trellis_cfg.svh
/* Trellis detector configuration: sample and metric widths, survivor depth
   and output queue depth */

`ifndef TRELLIS_CFG_SVH
`define TRELLIS_CFG_SVH

// signed width of one I or Q sample
`define SAMPLE_W 12

// path metric width, sized for one symbol of growth above the
// normalization threshold
`define METRIC_W 18

// survivor length in symbols, also the decision delay
`define TRACE_DEPTH 16

// decided-bit queue entries
`define QUEUE_DEPTH 4

`endif

// File: testbench/tbTrellisDetector.sv
/* Testbench for the trellis detector: golden-file stimulus, random input
   gaps and output stalls, bit-exact decision checks */

`timescale 1ns/1ns
`include "trellis_cfg.svh"

module tbTrellisDetector import trellisPkg::*; ();

  localparam int numSym   = 48;
  localparam int numOut   = numSym - `TRACE_DEPTH;
  localparam int cleanSym = 24;

  logic      clk;
  logic      reset;
  iqSample_t sampleIn;
  logic      sampleValid;
  logic      sampleReady;
  logic      bitOut;
  logic      bitValid;
  logic      bitReady;

  logic [15:0] golden [0:numSym*5-1];
  logic        outQ [$];
  logic [15:0] lfsrState;
  int          acceptCount;
  logic        earlyValid;
  logic        readyLowSeen;
  int          testErrors;
  int          passCount;
  int          failCount;

  trellisDetector dut_i (
    .clk, .reset, .sampleIn, .sampleValid, .sampleReady, .bitOut, .bitValid, .bitReady
  );

  // 100 ns clock
  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ------------------------------------------------------------------------
  // output capture and monitors
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      acceptCount = 0;
    end else begin
      if (bitValid && bitReady) begin
        outQ.push_back(bitOut);
      end
      // bit 0 needs TRACE_DEPTH+1 full symbols first
      if (bitValid && acceptCount < 2 * (`TRACE_DEPTH + 1)) begin
        earlyValid = 1'b1;
      end
      // intake stopped while bits sit in the queue
      if (!sampleReady && bitValid) begin
        readyLowSeen = 1'b1;
      end
      if (sampleValid && sampleReady) begin
        acceptCount++;
      end
    end
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic int lfsrBits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int k = 0; k < n; k++) begin
      fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], fb};
      v         = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  task automatic abortOnTimeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Something failed");
    $finish;
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      testErrors++;
    end
  endtask

  task automatic finishTest(input string name);
    if (testErrors == 0) begin
      $display("test %s: passed", name);
      passCount++;
    end else begin
      $display("test %s: failed with %0d errors", name, testErrors);
      failCount++;
    end
    testErrors = 0;
  endtask

  // reset for 8 cycles, ends 10 ns after an edge
  task automatic applyReset();
    reset       = 1'b1;
    sampleValid = 1'b0;
    bitReady    = 1'b1;
    repeat (8) @(posedge clk);
    outQ.delete();
    earlyValid   = 1'b0;
    readyLowSeen = 1'b0;
    #10;
    reset = 1'b0;
  endtask

  // sends nSym symbols, optionally drains the expected decisions
  task automatic runStream(input int nSym, input bit stalls, input bit drain);
    int waitCycles;
    bit accepted;
    for (int s = 0; s < nSym; s++) begin
      for (int h = 0; h < 2; h++) begin
        sampleIn.i = golden[5 * s + 2 * h][`SAMPLE_W-1:0];
        sampleIn.q = golden[5 * s + 2 * h + 1][`SAMPLE_W-1:0];
        accepted   = 1'b0;
        waitCycles = 0;
        while (!accepted) begin
          // roughly one gap in four under stalls
          sampleValid = stalls ? (lfsrBits(2) != 0) : 1'b1;
          bitReady    = stalls ? lfsrBits(1) : 1'b1;
          @(posedge clk);
          accepted = sampleValid && sampleReady;
          #10;
          waitCycles++;
          if (waitCycles > 200) begin
            abortOnTimeout("sample acceptance");
          end
        end
      end
    end
    sampleValid = 1'b0;
    if (drain) begin
      waitCycles = 0;
      while (outQ.size() < nSym - `TRACE_DEPTH) begin
        bitReady = stalls ? lfsrBits(1) : 1'b1;
        @(posedge clk);
        #10;
        waitCycles++;
        if (waitCycles > 500) begin
          abortOnTimeout("remaining decisions");
        end
      end
      // settle window to catch extra bits
      bitReady = 1'b1;
      repeat (20) @(posedge clk);
      #10;
    end
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin
    reset        = 1'b1;
    sampleIn     = '0;
    sampleValid  = 1'b0;
    bitReady     = 1'b1;
    lfsrState    = 16'd33902;
    earlyValid   = 1'b0;
    readyLowSeen = 1'b0;
    testErrors   = 0;
    passCount    = 0;
    failCount    = 0;
    $readmemh("testbench/trellis_golden.dat", golden);

    // clean stream, sink always ready
    applyReset();
    runStream(numSym, 1'b0, 1'b1);
    for (int k = 0; k < cleanSym && k < outQ.size(); k++) begin
      checkBit($sformatf("bitOut[%0d]", k), outQ[k], golden[5 * k + 4][0]);
    end
    checkCount("clean decisions", (outQ.size() < cleanSym) ? outQ.size() : cleanSym, cleanSym);
    finishTest("noiseless");

    // noisy symbols of the same run
    for (int k = cleanSym; k < numOut && k < outQ.size(); k++) begin
      checkBit($sformatf("bitOut[%0d]", k), outQ[k], golden[5 * k + 4][0]);
    end
    finishTest("noisy");

    // nothing before the survivor fill, fixed total
    checkBit("earlyValid", earlyValid, 1'b0);
    checkCount("decision count", outQ.size(), numOut);
    finishTest("decision delay");

    // random gaps and sink stalls
    applyReset();
    runStream(numSym, 1'b1, 1'b1);
    checkCount("decision count", outQ.size(), numOut);
    for (int k = 0; k < numOut && k < outQ.size(); k++) begin
      checkBit($sformatf("bitOut[%0d]", k), outQ[k], golden[5 * k + 4][0]);
    end
    checkBit("sampleReady low seen", readyLowSeen, 1'b1);
    checkBit("earlyValid", earlyValid, 1'b0);
    finishTest("back-pressure");

    // partial stream, then reset with data in flight
    applyReset();
    runStream(20, 1'b1, 1'b0);
    applyReset();
    checkBit("bitValid", bitValid, 1'b0);
    runStream(numSym, 1'b0, 1'b1);
    checkCount("decision count", outQ.size(), numOut);
    for (int k = 0; k < numOut && k < outQ.size(); k++) begin
      checkBit($sformatf("bitOut[%0d]", k), outQ[k], golden[5 * k + 4][0]);
    end
    finishTest("reset mid-stream");

    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: testbench/trellis_golden.dat
// per symbol: I0 Q0 I1 Q1 (12-bit two's complement) then the transmitted bit
// symbols 0..23 noiseless at 256 per unit, symbols 24..47 with bounded noise
200 F00 E00 F00 1
E00 100 E00 100 0
200 F00 E00 100 1
200 100 200 F00 1
E00 100 E00 F00 0
E00 F00 200 F00 0
200 F00 E00 F00 1
E00 100 E00 100 0
200 F00 E00 100 1
200 100 200 F00 1
200 100 200 100 1
E00 100 E00 F00 0
200 F00 E00 100 1
E00 100 E00 100 0
E00 F00 200 F00 0
E00 F00 200 100 0
200 F00 E00 F00 1
200 100 200 F00 1
E00 100 E00 F00 0
200 F00 E00 100 1
200 100 200 F00 1
E00 100 E00 F00 0
E00 F00 200 F00 0
200 F00 E00 F00 1
E2C 13A DD4 0D4 0
1C8 EC8 E48 11E 1
DE0 0C0 E16 148 0
E48 F30 238 EDC 0
21A F22 DBC F44 1
1E4 0F2 24C EB6 1
1F0 148 1C8 0D4 1
E16 11E DD4 F30 0
238 EDC E2C 0C0 1
DBC 13A E48 0F2 0
24C F44 DE0 148 1
E2C 0D4 E16 11E 0
DD4 EB6 1F0 F22 0
1C8 F30 E48 EC8 1
21A 0C0 238 F44 1
E48 13A DBC EDC 0
E16 EC8 24C F30 0
DE0 F22 1E4 0F2 0
238 EB6 DD4 F44 1
E2C 148 E16 0C0 0
1F0 F30 DE0 13A 1
24C 0D4 1C8 EC8 1
DBC 11E E48 F22 0
21A EDC E2C 0F2 1
